// ==== tb.f ====
src/roce_rx_pkg.sv
src/sync_fifo.sv
src/payload_realigner.sv
src/csum_checker.sv
src/frame_forwarder.sv
src/roce_rx_top.sv
sim/roce_rx_checker.sv
sim/tb_scoreboard.sv
sim/tb_top.sv

// ==== sim/tb_top.sv ====
`default_nettype none

module tb_top
  import roce_rx_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FRAMES = 200;
  localparam int MIN_BEATS  = 3;
  localparam int MAX_BEATS  = 12;
  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT_NS = NUM_FRAMES * MAX_BEATS * 4 * CLK_PERIOD;

  logic  clk;
  logic  rst_n;
  beat_t in_beat;
  logic  in_valid;
  logic  in_ready;
  logic  out_full;
  beat_t out_word;
  logic  out_valid;

  logic   drain_done;
  logic   stim_done;
  int     sb_errors;
  int     pending_words;
  int     total_errors;
  integer seed;

  // frame beats, lengths and idle gaps drawn before the run
  data_t beats [NUM_FRAMES*MAX_BEATS];
  int    lens  [NUM_FRAMES];
  int    gaps  [NUM_FRAMES];

  roce_rx_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_full  (out_full),
    .out_word  (out_word),
    .out_valid (out_valid)
  );

  tb_scoreboard u_sb (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_word      (out_word),
    .out_valid     (out_valid),
    .drain_done    (drain_done),
    .error_count   (sb_errors),
    .pending_words (pending_words)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic half_t csum_fold(input int unsigned total);
    int unsigned s;
    s = total;
    while (s > 32'hffff) begin
      s = (s & 32'hffff) + (s >> 16);
    end
    return half_t'(s);
  endfunction

  // ************************************************************
  // stimulus
  // ************************************************************

  task automatic build_frames();
    int          n;
    int          base;
    bit          good;
    int unsigned total;
    half_t       fill;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      n        = MIN_BEATS + ($unsigned($random(seed)) % (MAX_BEATS - MIN_BEATS + 1));
      good     = ($unsigned($random(seed)) % 100) < 70;
      base     = f * MAX_BEATS;
      lens[f]  = n;
      gaps[f]  = ($unsigned($random(seed)) % 2) ? 0 : 1 + ($unsigned($random(seed)) % 4);
      total    = 0;
      for (int b = 0; b < n; b++) begin
        beats[base+b] = $random(seed);
        if (b == 0) begin
          beats[base][15:0] = '0;
        end
        total += beats[base+b][15:0] + beats[base+b][31:16];
      end
      // lower half of beat 0 sets the checksum outcome
      fill = ~csum_fold(total);
      if (!good) begin
        do begin
          fill = half_t'($random(seed));
        end while (csum_fold(total + fill) == 16'hffff);
      end
      beats[base][15:0] = fill;
    end
  endtask

  task automatic send_frame(input int f);
    beat_t b;
    for (int i = 0; i < lens[f]; i++) begin
      b.data   = beats[f*MAX_BEATS+i];
      b.last   = (i == lens[f] - 1);
      in_beat  = b;
      in_valid = 1'b1;
      // in_ready only moves on the rising edge
      while (!in_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  // receiver back-pressure with an occasional long full period
  initial begin
    int r;
    int hold;
    hold = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (stim_done) begin
        out_full = 1'b0;
      end else if (hold > 0) begin
        hold--;
      end else begin
        r = $unsigned($random(seed)) % 100;
        if (r < 1) begin
          out_full = 1'b1;
          hold     = 40 + ($unsigned($random(seed)) % 40);
        end else begin
          out_full = (r < 40);
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired after %0d ns before all frames drained", TIMEOUT_NS);
    $display(">>> FAIL");
    $finish;
  end

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    seed       = 32'hfb73_e659;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_full   = 1'b0;
    drain_done = 1'b0;
    stim_done  = 1'b0;
    build_frames();

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
      repeat (gaps[f]) @(negedge clk);
    end
    stim_done = 1'b1;

    // let bad frames still in the fifo drain as well
    while (pending_words != 0) begin
      @(negedge clk);
    end
    repeat (2 * FRAME_FIFO_DEPTH) @(negedge clk);
    drain_done = 1'b1;
    @(negedge clk);

    total_errors = sb_errors + u_dut.u_checker.fail_count;
    $display("errors: scoreboard %0d, assertions %0d",
             sb_errors, u_dut.u_checker.fail_count);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_scoreboard.sv ====
`default_nettype none

module tb_scoreboard
  import roce_rx_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire beat_t in_beat,
  input  wire logic  in_valid,
  input  wire logic  in_ready,
  input  wire beat_t out_word,
  input  wire logic  out_valid,
  input  wire logic  drain_done,
  output int         error_count,
  output int         pending_words
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t frame_q[$];
  beat_t expect_q[$];
  int    expected_total;
  int    delivered;
  int    stall_cycles;
  int    back_to_back;
  logic  tail_cycle;
  logic  rst_q;
  logic  end_checked;

  // fold carries back in until the sum fits in 16 bits
  function automatic half_t fold_to_half(input int unsigned total);
    int unsigned s;
    s = total;
    while (s > 32'hffff) begin
      s = (s & 32'hffff) + (s >> 16);
    end
    return half_t'(s);
  endfunction

  initial begin
    error_count    = 0;
    pending_words  = 0;
    expected_total = 0;
    delivered      = 0;
    stall_cycles   = 0;
    back_to_back   = 0;
    tail_cycle     = 1'b0;
    rst_q          = 1'b0;
    end_checked    = 1'b0;
  end

  // outputs idle and input open at the first edge out of reset
  task automatic check_reset_state();
    if (out_valid !== 1'b0) begin
      error_count++;
      $display("MISMATCH reset_state out_valid expected 0 actual %b", out_valid);
    end
    if (in_ready !== 1'b1) begin
      error_count++;
      $display("MISMATCH reset_state in_ready expected 1 actual %b", in_ready);
    end
  endtask

  // ************************************************************
  // end of run checks
  // ************************************************************

  task automatic check_end_of_run();
    if (expect_q.size() != 0) begin
      error_count++;
      $display("ERROR: %0d expected words were never delivered", expect_q.size());
    end
    if (delivered != expected_total) begin
      error_count++;
      $display("MISMATCH input_flow_control expected %0d actual %0d",
               expected_total, delivered);
    end
    if (stall_cycles == 0) begin
      error_count++;
      $display("ERROR: in_ready never dropped, input flow control was not exercised");
    end
    if (back_to_back == 0) begin
      error_count++;
      $display("ERROR: no frame started in the tail cycle of the previous frame");
    end
  endtask

  // ************************************************************
  // input side model and output compare
  // ************************************************************

  always @(posedge clk) begin
    int unsigned total;
    int          n;
    beat_t       w;
    if (rst_n && !rst_q) begin
      check_reset_state();
    end
    rst_q = rst_n;

    if (rst_n) begin
      if (in_valid && !in_ready) begin
        stall_cycles++;
      end
      if (in_valid && in_ready) begin
        // first beat landing in the tail cycle of the previous frame
        if (frame_q.size() == 0 && tail_cycle) begin
          back_to_back++;
        end
        frame_q.push_back(in_beat.data);
        if (in_beat.last) begin
          total = 0;
          foreach (frame_q[i]) begin
            total += frame_q[i][15:0] + frame_q[i][31:16];
          end
          n = frame_q.size();
          if (fold_to_half(total) == 16'hffff) begin
            for (int k = 0; k < n - 2; k++) begin
              w.last = (k == n - 3);
              if (k < n - 3) begin
                w.data = {frame_q[k+3][15:0], frame_q[k+2][31:16]};
              end else begin
                w.data = {16'h0000, frame_q[n-1][31:16]};
              end
              expect_q.push_back(w);
            end
            expected_total += n - 2;
          end
          frame_q.delete();
        end
      end
      tail_cycle = in_valid && in_ready && in_beat.last;

      if (out_valid) begin
        delivered++;
        if (expect_q.size() == 0) begin
          error_count++;
          $display("ERROR: word %h delivered while no good frame word was pending", out_word);
        end else begin
          w = expect_q.pop_front();
          if (out_word !== w) begin
            error_count++;
            $display("MISMATCH good_frame_realign word %0d expected %h actual %h",
                     delivered - 1, w, out_word);
          end
        end
      end
      pending_words = expect_q.size();
    end

    if (drain_done && !end_checked) begin
      end_checked = 1'b1;
      check_end_of_run();
    end
  end

endmodule

`default_nettype wire

// ==== sim/roce_rx_checker.sv ====
`default_nettype none

module roce_rx_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic in_ready,
  input wire logic out_full,
  input wire logic out_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // a word may only leave while the receiver has room
  out_valid_needs_room: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> !out_full
  ) else begin
    fail_count++;
    $error("out_valid was high while out_full was high");
  end

  // no output activity while reset is held
  quiet_in_reset: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else begin
    fail_count++;
    $error("out_valid was high while rst_n was low");
  end

  // both fifos are empty once reset is released
  ready_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> (in_ready && !out_valid)
  ) else begin
    fail_count++;
    $error("in_ready low or out_valid high right after reset");
  end

endmodule

bind roce_rx_top roce_rx_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_full  (out_full),
  .out_valid (out_valid)
);

`default_nettype wire

// ==== src/roce_rx_top.sv ====
`default_nettype none

module roce_rx_top
  import roce_rx_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire beat_t in_beat,
  input  wire logic  in_valid,
  output logic       in_ready,
  input  wire logic  out_full,
  output beat_t      out_word,
  output logic       out_valid
);

  logic accept;

  logic  ra_wr_en;
  beat_t ra_word;

  logic csum_wr;
  logic csum_good;

  beat_t                   frame_word;
  logic                    frame_empty;
  logic                    frame_rd;
  logic [FRAME_CNT_W-1:0]  frame_free;

  logic                     verdict_good;
  logic                     verdict_empty;
  logic                     verdict_rd;
  logic [VERDICT_CNT_W-1:0] verdict_free;

  // ************************************************************
  // input flow control
  // ************************************************************

  // two frame entries, the tail word lands a cycle after the last beat
  assign in_ready = (frame_free >= FRAME_CNT_W'(2)) && (verdict_free != '0);
  assign accept   = in_valid && in_ready;

  // realigner and checksum see the same accepted beats
  payload_realigner u_realigner (
    .clk    (clk),
    .rst_n  (rst_n),
    .accept (accept),
    .beat   (in_beat),
    .wr_en  (ra_wr_en),
    .word   (ra_word)
  );

  csum_checker u_csum (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept       (accept),
    .beat         (in_beat),
    .verdict_wr   (csum_wr),
    .verdict_good (csum_good)
  );

  sync_fifo #(
    .WIDTH ($bits(beat_t)),
    .DEPTH (FRAME_FIFO_DEPTH)
  ) u_frame_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (ra_wr_en),
    .din   (ra_word),
    .rd_en (frame_rd),
    .dout  (frame_word),
    .empty (frame_empty),
    .free  (frame_free)
  );

  sync_fifo #(
    .WIDTH (1),
    .DEPTH (VERDICT_FIFO_DEPTH)
  ) u_verdict_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (csum_wr),
    .din   (csum_good),
    .rd_en (verdict_rd),
    .dout  (verdict_good),
    .empty (verdict_empty),
    .free  (verdict_free)
  );

  frame_forwarder u_forwarder (
    .clk           (clk),
    .rst_n         (rst_n),
    .verdict_empty (verdict_empty),
    .verdict_good  (verdict_good),
    .frame_empty   (frame_empty),
    .frame_word    (frame_word),
    .out_full      (out_full),
    .verdict_rd    (verdict_rd),
    .frame_rd      (frame_rd),
    .out_word      (out_word),
    .out_valid     (out_valid)
  );

endmodule

`default_nettype wire

// ==== src/frame_forwarder.sv ====
`default_nettype none

module frame_forwarder
  import roce_rx_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  verdict_empty,
  input  wire logic  verdict_good,
  input  wire logic  frame_empty,
  input  wire beat_t frame_word,
  input  wire logic  out_full,
  output logic       verdict_rd,
  output logic       frame_rd,
  output beat_t      out_word,
  output logic       out_valid
);

  fwd_state_e state_q;
  fwd_state_e state_d;

  // ************************************************************
  // fifo pops
  // ************************************************************

  // take a verdict only once its frame has started to land
  assign verdict_rd = (state_q == FW_IDLE) && !verdict_empty && !frame_empty;

  // drop mode also waits for room, so both modes pace alike
  assign frame_rd = (state_q != FW_IDLE) && !frame_empty && !out_full;

  assign out_valid = frame_rd && (state_q == FW_PASS);
  assign out_word  = frame_word;

  // ************************************************************
  // frame state
  // ************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      FW_IDLE: begin
        if (verdict_rd) begin
          state_d = verdict_good ? FW_PASS : FW_DROP;
        end
      end
      FW_PASS, FW_DROP: begin
        // end of frame once its last word is gone
        if (frame_rd && frame_word.last) begin
          state_d = FW_IDLE;
        end
      end
      default: begin
        state_d = FW_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/csum_checker.sv ====
`default_nettype none

module csum_checker
  import roce_rx_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  accept,
  input  wire beat_t beat,
  output logic       verdict_wr,
  output logic       verdict_good
);

  half_t acc_q;
  half_t sum_lo;
  half_t sum_next;

  // ones'-complement add with end-around carry
  function automatic half_t oc_add(input half_t a, input half_t b);
    logic [HALF_W:0] raw;
    raw = {1'b0, a} + {1'b0, b};
    return raw[HALF_W-1:0] + half_t'(raw[HALF_W]);
  endfunction

  // both halves of the beat go into the sum, header included
  assign sum_lo   = oc_add(acc_q, beat.data[HALF_W-1:0]);
  assign sum_next = oc_add(sum_lo, beat.data[DATA_W-1:HALF_W]);

  // ************************************************************
  // verdict on the last beat
  // ************************************************************

  assign verdict_wr   = accept && beat.last;
  assign verdict_good = (sum_next == {HALF_W{1'b1}});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (accept) begin
      // restart for the next frame
      if (beat.last) begin
        acc_q <= '0;
      end else begin
        acc_q <= sum_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/payload_realigner.sv ====
`default_nettype none

module payload_realigner
  import roce_rx_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  accept,
  input  wire beat_t beat,
  output logic       wr_en,
  output beat_t      word
);

  realign_state_e state_q;
  realign_state_e state_d;

  // carried upper half of the previous beat
  half_t store_q;
  logic  store_en;

  half_t beat_hi;
  half_t beat_lo;

  assign beat_hi = beat.data[DATA_W-1:HDR_SPLIT_BIT];
  assign beat_lo = beat.data[HDR_SPLIT_BIT-1:0];

  // ************************************************************
  // next state and frame fifo write
  // ************************************************************

  always_comb begin
    state_d  = state_q;
    wr_en    = 1'b0;
    word     = '0;
    store_en = 1'b0;

    case (state_q)
      RA_IDLE: begin
        // first header beat, nothing to keep
        if (accept) begin
          state_d = RA_SKIP;
        end
      end
      RA_SKIP: begin
        if (accept) begin
          state_d = RA_HEAD;
        end
      end
      RA_HEAD: begin
        // low half is the header tail, upper half starts the payload
        if (accept) begin
          store_en = 1'b1;
          state_d  = beat.last ? RA_TAIL : RA_BODY;
        end
      end
      RA_BODY: begin
        if (accept) begin
          wr_en     = 1'b1;
          word.data = {beat_lo, store_q};
          store_en  = 1'b1;
          if (beat.last) begin
            state_d = RA_TAIL;
          end
        end
      end
      RA_TAIL: begin
        // leftover half word, zero padded on top
        wr_en     = 1'b1;
        word.last = 1'b1;
        word.data = {{HALF_W{1'b0}}, store_q};
        state_d   = accept ? RA_SKIP : RA_IDLE;
      end
      default: begin
        state_d = RA_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RA_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (store_en) begin
      store_q <= beat_hi;
    end
  end

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     wr_en,
  input  wire logic [WIDTH-1:0]         din,
  input  wire logic                     rd_en,
  output logic      [WIDTH-1:0]         dout,
  output logic                          empty,
  output logic      [$clog2(DEPTH):0]   free
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // storage array, written at the tail
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, unchanged on a simultaneous push and pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read-ahead: head entry is always on dout
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign free  = DEPTH[PTR_W:0] - count;

endmodule

`default_nettype wire

// ==== src/roce_rx_pkg.sv ====
`default_nettype none

package roce_rx_pkg;

  // ************************************************************
  // widths and depths
  // ************************************************************

  localparam int DATA_W = 32;
  localparam int HALF_W = 16;

  // two whole beats plus one half word of header
  localparam int HDR_BYTES = 10;

  // bit position inside a beat where the payload starts
  localparam int HDR_SPLIT_BIT = (HDR_BYTES % (DATA_W / 8)) * 8;

  localparam int FRAME_FIFO_DEPTH   = 32;
  localparam int VERDICT_FIFO_DEPTH = 4;

  // free-entry counters need one extra bit to hold a full depth
  localparam int FRAME_CNT_W   = $clog2(FRAME_FIFO_DEPTH) + 1;
  localparam int VERDICT_CNT_W = $clog2(VERDICT_FIFO_DEPTH) + 1;

  // ************************************************************
  // types
  // ************************************************************

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [HALF_W-1:0] half_t;

  // input beat, frame fifo entry and output word
  typedef struct packed {
    logic  last;
    data_t data;
  } beat_t;

  typedef enum logic [2:0] {
    RA_IDLE,
    RA_SKIP,
    RA_HEAD,
    RA_BODY,
    RA_TAIL
  } realign_state_e;

  typedef enum logic [1:0] {
    FW_IDLE,
    FW_PASS,
    FW_DROP
  } fwd_state_e;

endpackage

`default_nettype wire
